//--- hdl/snn_pkg.sv
// SNN layer shared definitions

package snn_pkg;

    // input spike word and popcount grouping
    localparam int SPIKE_W = 32;
    localparam int GROUPS = 4;

    // spike count covers 0 to 32
    localparam int COUNT_W = 6;

    // signed membrane potential
    localparam int MEMBRANE_W = 16;

    // register selectors in the low two address bits
    localparam logic [1:0] CFG_REG_CONN = 2'd0;
    localparam logic [1:0] CFG_REG_SIGN = 2'd1;
    localparam logic [1:0] CFG_REG_PARAM = 2'd2;

    // parameter register layout, threshold in the top half
    typedef struct packed {
        logic signed [15:0] threshold;
        logic [3:0]         leak_shift;
        logic [3:0]         refractory;
        logic [7:0]         reserved;
    } neuron_param_t;

    // one config data word, read as a mask or as neuron parameters
    typedef union packed {
        logic [31:0]   raw;
        neuron_param_t param;
    } cfg_word_u;

    // threshold out of reach until configured
    localparam neuron_param_t PARAM_RESET = '{
        threshold:  16'sh7fff,
        leak_shift: 4'd0,
        refractory: 4'd0,
        reserved:   8'd0
    };

endpackage

//--- hdl/spike_popcount8.sv
// eight-bit spike popcount

module spike_popcount8 (
    input  logic [7:0] i_spikes,
    output logic [3:0] o_count
);

    // full adder cell, returns {carry, sum}
    function automatic logic [1:0] full_add(input logic a, input logic b, input logic cin);
        logic sum;
        logic carry;
        sum = a ^ b ^ cin;
        carry = (a & b) | (a & cin) | (b & cin);
        return {carry, sum};
    endfunction

    logic s1, s2, s3, s4, s5, s6, s7;
    logic c1, c2, c3, c4, c5, c6, c7;

    always_comb begin
        // weight-one level, two triples then the last two bits
        {c1, s1} = full_add(i_spikes[0], i_spikes[1], i_spikes[2]);
        {c2, s2} = full_add(i_spikes[3], i_spikes[4], i_spikes[5]);
        {c3, s3} = full_add(s1, s2, i_spikes[6]);
        {c4, s4} = full_add(s3, i_spikes[7], 1'b0);

        // weight-two carries folded together
        {c5, s5} = full_add(c1, c3, c2);
        {c6, s6} = full_add(s5, c4, 1'b0);

        // weight-four and weight-eight
        {c7, s7} = full_add(c5, c6, 1'b0);

        o_count = {c7, s7, s6, s4};

        assert (o_count <= 4'd8)
            else $error("popcount of %b gave %0d", i_spikes, o_count);
    end

endmodule

//--- hdl/synapse_counter.sv
// per-neuron synapse spike counter

module synapse_counter (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_step,
    input  logic [snn_pkg::SPIKE_W-1:0]  i_spikes,
    input  logic [snn_pkg::SPIKE_W-1:0]  i_conn_mask,
    input  logic [snn_pkg::SPIKE_W-1:0]  i_sign_mask,
    output logic [snn_pkg::COUNT_W-1:0]  o_excit,
    output logic [snn_pkg::COUNT_W-1:0]  o_inhib,
    output logic                         o_count_valid
);

    localparam int GROUP_W = snn_pkg::SPIKE_W / snn_pkg::GROUPS;

    logic [snn_pkg::SPIKE_W-1:0] excit_vec;
    logic [snn_pkg::SPIKE_W-1:0] inhib_vec;
    logic [3:0]                  excit_part [snn_pkg::GROUPS];
    logic [3:0]                  inhib_part [snn_pkg::GROUPS];
    logic [snn_pkg::COUNT_W-1:0] excit_sum;
    logic [snn_pkg::COUNT_W-1:0] inhib_sum;

    // sign bit set means an inhibitory synapse
    assign excit_vec = i_spikes & i_conn_mask & ~i_sign_mask;
    assign inhib_vec = i_spikes & i_conn_mask & i_sign_mask;

    // one popcount per byte and polarity
    for (genvar g = 0; g < snn_pkg::GROUPS; g++) begin : g_group
        spike_popcount8 u_excit_pop (
            .i_spikes ( excit_vec[g*GROUP_W +: GROUP_W] ),
            .o_count  ( excit_part[g]                   )
        );

        spike_popcount8 u_inhib_pop (
            .i_spikes ( inhib_vec[g*GROUP_W +: GROUP_W] ),
            .o_count  ( inhib_part[g]                   )
        );
    end

    // add the byte counts
    always_comb begin
        excit_sum = '0;
        inhib_sum = '0;
        for (int g = 0; g < snn_pkg::GROUPS; g++) begin
            excit_sum = excit_sum + snn_pkg::COUNT_W'(excit_part[g]);
            inhib_sum = inhib_sum + snn_pkg::COUNT_W'(inhib_part[g]);
        end
    end

    // counts captured at the step edge
    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_excit <= excit_sum;
            o_inhib <= inhib_sum;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_count_valid <= 1'b0;
        end else begin
            o_count_valid <= i_step;
        end
    end

    // excitatory and inhibitory synapses never overlap
    a_count_bound: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_count_valid |-> (int'(o_excit) + int'(o_inhib) <= snn_pkg::SPIKE_W)
    ) else $error("excit %0d plus inhib %0d above spike width", o_excit, o_inhib);

endmodule

//--- hdl/lif_neuron.sv
// leaky integrate-and-fire neuron

module lif_neuron (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_count_valid,
    input  logic [snn_pkg::COUNT_W-1:0]         i_excit,
    input  logic [snn_pkg::COUNT_W-1:0]         i_inhib,
    input  logic signed [snn_pkg::MEMBRANE_W-1:0] i_threshold,
    input  logic [3:0]                          i_leak_shift,
    input  logic [3:0]                          i_refractory,
    output logic                                o_fire,
    output logic                                o_fire_valid
);

    // two guard bits hold the sum before clamping
    localparam int WIDE_W = snn_pkg::MEMBRANE_W + 2;
    localparam logic signed [WIDE_W-1:0] MEM_MAX = 2**(snn_pkg::MEMBRANE_W-1) - 1;
    localparam logic signed [WIDE_W-1:0] MEM_MIN = -(2**(snn_pkg::MEMBRANE_W-1));

    logic signed [snn_pkg::MEMBRANE_W-1:0] membrane;
    logic [3:0]                            refr_cnt;
    logic signed [snn_pkg::MEMBRANE_W-1:0] leak;
    logic signed [WIDE_W-1:0]              wide_sum;
    logic signed [snn_pkg::MEMBRANE_W-1:0] sat_next;
    logic                                  fire_next;

    always_comb begin
        // zero shift disables the leak
        if (i_leak_shift == 4'd0) begin
            leak = '0;
        end else begin
            leak = membrane >>> i_leak_shift;
        end

        wide_sum = membrane - leak
                 + $signed({1'b0, i_excit})
                 - $signed({1'b0, i_inhib});

        // clamp to the signed membrane range
        if (wide_sum > MEM_MAX) begin
            sat_next = snn_pkg::MEMBRANE_W'(MEM_MAX);
        end else if (wide_sum < MEM_MIN) begin
            sat_next = snn_pkg::MEMBRANE_W'(MEM_MIN);
        end else begin
            sat_next = snn_pkg::MEMBRANE_W'(wide_sum);
        end

        fire_next = (refr_cnt == 4'd0) && (sat_next >= i_threshold);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            membrane     <= '0;
            refr_cnt     <= '0;
            o_fire       <= 1'b0;
            o_fire_valid <= 1'b0;
        end else begin
            o_fire_valid <= i_count_valid;
            if (!i_count_valid) begin
                o_fire <= 1'b0;
            end else if (refr_cnt != 4'd0) begin
                // still refractory, input ignored
                refr_cnt <= refr_cnt - 4'd1;
                membrane <= '0;
                o_fire   <= 1'b0;
            end else if (fire_next) begin
                refr_cnt <= i_refractory;
                membrane <= '0;
                o_fire   <= 1'b1;
            end else begin
                membrane <= sat_next;
                o_fire   <= 1'b0;
            end
        end
    end

    a_fire_qualified: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_fire |-> o_fire_valid
    ) else $error("fire without fire valid");

    // a count seen during refractory never leads to a fire
    a_no_fire_refractory: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_count_valid && refr_cnt != 4'd0) |=> !o_fire
    ) else $error("fired during refractory period");

endmodule

//--- hdl/neuron_config.sv
// neuron configuration registers

module neuron_config #(
    parameter int N_NEURONS = 4
) (
    input  logic                                      i_clk,
    input  logic                                      i_reset,
    input  logic                                      i_cfg_we,
    input  logic [((N_NEURONS > 1) ? $clog2(N_NEURONS) : 1) + 1:0] i_cfg_addr,
    input  snn_pkg::cfg_word_u                        i_cfg_data,
    output logic [N_NEURONS*snn_pkg::SPIKE_W-1:0]     o_conn_mask,
    output logic [N_NEURONS*snn_pkg::SPIKE_W-1:0]     o_sign_mask,
    output logic [N_NEURONS*snn_pkg::MEMBRANE_W-1:0]  o_threshold,
    output logic [N_NEURONS*4-1:0]                    o_leak_shift,
    output logic [N_NEURONS*4-1:0]                    o_refractory
);

    localparam int IDX_W = (N_NEURONS > 1) ? $clog2(N_NEURONS) : 1;

    logic [IDX_W-1:0]            cfg_idx;
    logic [1:0]                  cfg_sel;
    logic [snn_pkg::SPIKE_W-1:0] conn_q  [N_NEURONS];
    logic [snn_pkg::SPIKE_W-1:0] sign_q  [N_NEURONS];
    snn_pkg::neuron_param_t      param_q [N_NEURONS];

    // neuron index above the two selector bits
    assign cfg_idx = i_cfg_addr[IDX_W+1:2];
    assign cfg_sel = i_cfg_addr[1:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int n = 0; n < N_NEURONS; n++) begin
                conn_q[n]  <= '0;
                sign_q[n]  <= '0;
                param_q[n] <= snn_pkg::PARAM_RESET;
            end
        end else if (i_cfg_we) begin
            for (int n = 0; n < N_NEURONS; n++) begin
                if (cfg_idx == IDX_W'(n)) begin
                    case (cfg_sel)
                        snn_pkg::CFG_REG_CONN:  conn_q[n]  <= i_cfg_data.raw;
                        snn_pkg::CFG_REG_SIGN:  sign_q[n]  <= i_cfg_data.raw;
                        snn_pkg::CFG_REG_PARAM: param_q[n] <= i_cfg_data.param;
                        default: ;
                    endcase
                end
            end
        end
    end

    // flatten per-neuron fields onto the output buses
    always_comb begin
        for (int n = 0; n < N_NEURONS; n++) begin
            o_conn_mask[n*snn_pkg::SPIKE_W +: snn_pkg::SPIKE_W]        = conn_q[n];
            o_sign_mask[n*snn_pkg::SPIKE_W +: snn_pkg::SPIKE_W]        = sign_q[n];
            o_threshold[n*snn_pkg::MEMBRANE_W +: snn_pkg::MEMBRANE_W]  = param_q[n].threshold;
            o_leak_shift[n*4 +: 4]                                     = param_q[n].leak_shift;
            o_refractory[n*4 +: 4]                                     = param_q[n].refractory;
        end
    end

    a_legal_sel: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_cfg_we |-> (cfg_sel != 2'd3)
    ) else $error("config write to illegal selector 3");

    a_legal_idx: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_cfg_we |-> (int'(cfg_idx) < N_NEURONS)
    ) else $error("config write to neuron %0d out of range", cfg_idx);

endmodule

//--- hdl/snn_layer.sv
// spiking neuron layer top

module snn_layer #(
    parameter int N_NEURONS = 4
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_cfg_we,
    input  logic [((N_NEURONS > 1) ? $clog2(N_NEURONS) : 1) + 1:0] i_cfg_addr,
    input  snn_pkg::cfg_word_u            i_cfg_data,
    input  logic                          i_step,
    input  logic [snn_pkg::SPIKE_W-1:0]   i_spikes,
    output logic [N_NEURONS-1:0]          o_spikes,
    output logic                          o_spikes_valid
);

    logic [N_NEURONS*snn_pkg::SPIKE_W-1:0]    conn_mask;
    logic [N_NEURONS*snn_pkg::SPIKE_W-1:0]    sign_mask;
    logic [N_NEURONS*snn_pkg::MEMBRANE_W-1:0] threshold;
    logic [N_NEURONS*4-1:0]                   leak_shift;
    logic [N_NEURONS*4-1:0]                   refractory;
    logic [N_NEURONS-1:0]                     fire_valid;

    neuron_config #(
        .N_NEURONS ( N_NEURONS )
    ) u_neuron_config (
        .i_clk        ( i_clk      ),
        .i_reset      ( i_reset    ),
        .i_cfg_we     ( i_cfg_we   ),
        .i_cfg_addr   ( i_cfg_addr ),
        .i_cfg_data   ( i_cfg_data ),
        .o_conn_mask  ( conn_mask  ),
        .o_sign_mask  ( sign_mask  ),
        .o_threshold  ( threshold  ),
        .o_leak_shift ( leak_shift ),
        .o_refractory ( refractory )
    );

    for (genvar n = 0; n < N_NEURONS; n++) begin : g_neuron
        logic [snn_pkg::COUNT_W-1:0] excit;
        logic [snn_pkg::COUNT_W-1:0] inhib;
        logic                        count_valid;

        synapse_counter u_synapse_counter (
            .i_clk         ( i_clk                                            ),
            .i_reset       ( i_reset                                          ),
            .i_step        ( i_step                                           ),
            .i_spikes      ( i_spikes                                         ),
            .i_conn_mask   ( conn_mask[n*snn_pkg::SPIKE_W +: snn_pkg::SPIKE_W] ),
            .i_sign_mask   ( sign_mask[n*snn_pkg::SPIKE_W +: snn_pkg::SPIKE_W] ),
            .o_excit       ( excit                                            ),
            .o_inhib       ( inhib                                            ),
            .o_count_valid ( count_valid                                      )
        );

        lif_neuron u_lif_neuron (
            .i_clk         ( i_clk                                                  ),
            .i_reset       ( i_reset                                                ),
            .i_count_valid ( count_valid                                            ),
            .i_excit       ( excit                                                  ),
            .i_inhib       ( inhib                                                  ),
            .i_threshold   ( threshold[n*snn_pkg::MEMBRANE_W +: snn_pkg::MEMBRANE_W] ),
            .i_leak_shift  ( leak_shift[n*4 +: 4]                                   ),
            .i_refractory  ( refractory[n*4 +: 4]                                   ),
            .o_fire        ( o_spikes[n]                                            ),
            .o_fire_valid  ( fire_valid[n]                                          )
        );
    end

    // every neuron runs the same pipeline, neuron 0 stands for all
    assign o_spikes_valid = fire_valid[0];

endmodule

//--- tests/snn_layer_tb.sv
// SNN layer testbench

module snn_layer_tb;

    localparam int N_NEURONS = 4;
    localparam int MAX_ROWS = 1400;
    localparam int DRAIN_LIMIT = 12;
    // valid seen after the second edge following the drive edge
    localparam int VALID_DELAY = 3;

    logic                 clk;
    logic                 reset;
    logic                 cfg_we;
    logic [3:0]           cfg_addr;
    snn_pkg::cfg_word_u   cfg_data;
    logic                 step;
    logic [31:0]          spikes;
    logic [N_NEURONS-1:0] out_spikes;
    logic                 out_valid;

    // operation table of config writes and steps in run order
    bit          row_is_cfg [MAX_ROWS];
    int          row_test   [MAX_ROWS];
    logic [3:0]  row_addr   [MAX_ROWS];
    logic [31:0] row_data   [MAX_ROWS];
    int          row_gap    [MAX_ROWS];
    logic [3:0]  row_exp    [MAX_ROWS];
    int          n_rows;

    // behavioral layer state
    logic [31:0] m_conn [N_NEURONS];
    logic [31:0] m_sign [N_NEURONS];
    int          m_thr  [N_NEURONS];
    int          m_leak [N_NEURONS];
    int          m_refr [N_NEURONS];
    int          m_mem  [N_NEURONS];
    int          m_rcnt [N_NEURONS];

    int         due_q [$];
    logic [3:0] exp_q [$];
    int         due_now;
    logic [3:0] exp_now;
    int         cycle;
    int         errors;
    int         checks;
    bit         timed_out;
    string      test_name [8];

    snn_layer #(
        .N_NEURONS ( N_NEURONS )
    ) i_snn_layer (
        .i_clk          ( clk        ),
        .i_reset        ( reset      ),
        .i_cfg_we       ( cfg_we     ),
        .i_cfg_addr     ( cfg_addr   ),
        .i_cfg_data     ( cfg_data   ),
        .i_step         ( step       ),
        .i_spikes       ( spikes     ),
        .o_spikes       ( out_spikes ),
        .o_spikes_valid ( out_valid  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] param_word(input logic [15:0] thr, input logic [3:0] leak,
                                               input logic [3:0] refr);
        return {thr, leak, refr, 8'h00};
    endfunction

    function automatic void add_cfg(input int t, input int n, input logic [1:0] sel,
                                    input logic [31:0] d);
        row_is_cfg[n_rows] = 1'b1;
        row_test[n_rows] = t;
        row_addr[n_rows] = {2'(n), sel};
        row_data[n_rows] = d;
        row_gap[n_rows] = 0;
        n_rows++;
    endfunction

    function automatic void add_step(input int t, input logic [31:0] s, input int gap);
        row_is_cfg[n_rows] = 1'b0;
        row_test[n_rows] = t;
        row_addr[n_rows] = '0;
        row_data[n_rows] = s;
        row_gap[n_rows] = gap;
        n_rows++;
    endfunction

    function automatic void model_write(input logic [3:0] addr, input logic [31:0] d);
        int n;
        n = int'(addr[3:2]);
        case (addr[1:0])
            2'd0: m_conn[n] = d;
            2'd1: m_sign[n] = d;
            2'd2: begin
                m_thr[n] = int'($signed(d[31:16]));
                m_leak[n] = int'(d[15:12]);
                m_refr[n] = int'(d[11:8]);
            end
            default: ;
        endcase
    endfunction

    // one time step of the neuron rule over all neurons
    function automatic logic [3:0] model_step(input logic [31:0] s);
        logic [3:0] fired;
        int ex;
        int inh;
        int leak;
        int next;
        fired = '0;
        for (int n = 0; n < N_NEURONS; n++) begin
            ex = 0;
            inh = 0;
            for (int b = 0; b < 32; b++) begin
                if (s[b] && m_conn[n][b]) begin
                    if (m_sign[n][b]) begin
                        inh++;
                    end else begin
                        ex++;
                    end
                end
            end
            if (m_rcnt[n] != 0) begin
                m_rcnt[n]--;
                m_mem[n] = 0;
            end else begin
                leak = (m_leak[n] == 0) ? 0 : (m_mem[n] >>> m_leak[n]);
                next = m_mem[n] - leak + ex - inh;
                if (next > 32767) begin
                    next = 32767;
                end else if (next < -32768) begin
                    next = -32768;
                end
                if (next >= m_thr[n]) begin
                    fired[n] = 1'b1;
                    m_mem[n] = 0;
                    m_rcnt[n] = m_refr[n];
                end else begin
                    m_mem[n] = next;
                end
            end
        end
        return fired;
    endfunction

    function automatic void build_tables();
        logic [31:0] patterns [10];
        logic [31:0] r;
        patterns = '{32'hffff_ffff, 32'h0000_0000, 32'h0000_00ff, 32'h0000_ff00,
                     32'h00ff_0000, 32'hff00_0000, 32'h0000_ffff, 32'hffff_0000,
                     32'h0000_0100, 32'h8000_0000};
        r = 32'h8a8a_c007;
        n_rows = 0;
        // reset threshold out of reach even with full input
        for (int n = 0; n < N_NEURONS; n++) add_cfg(1, n, snn_pkg::CFG_REG_CONN, '1);
        add_step(1, 32'hffff_ffff, 2);
        add_step(1, 32'h0000_0000, 2);
        // counting with threshold 1 and mixed polarities
        add_cfg(2, 1, snn_pkg::CFG_REG_SIGN, 32'hffff_0000);
        add_cfg(2, 2, snn_pkg::CFG_REG_CONN, 32'h0000_ff00);
        add_cfg(2, 3, snn_pkg::CFG_REG_CONN, 32'hff00_ff00);
        add_cfg(2, 3, snn_pkg::CFG_REG_SIGN, 32'hff00_0000);
        for (int n = 0; n < N_NEURONS; n++) begin
            add_cfg(2, n, snn_pkg::CFG_REG_PARAM, param_word(1, 0, 0));
        end
        for (int p = 0; p < 10; p++) add_step(2, patterns[p], p % 2);
        // integration with a different leak per neuron
        for (int n = 0; n < N_NEURONS; n++) begin
            add_cfg(3, n, snn_pkg::CFG_REG_CONN, 32'h0000_00ff);
            add_cfg(3, n, snn_pkg::CFG_REG_SIGN, 32'h0);
            add_cfg(3, n, snn_pkg::CFG_REG_PARAM, param_word(16'(20 * (n + 1)), 4'(n + 1), 0));
        end
        for (int k = 0; k < 6; k++) add_step(3, 32'h0000_000f, 1);
        for (int k = 0; k < 6; k++) add_step(3, 32'h0000_00ff, 0);
        // refractory periods 3, 1, 0 and 15
        for (int n = 0; n < N_NEURONS; n++) add_cfg(4, n, snn_pkg::CFG_REG_CONN, '1);
        add_cfg(4, 0, snn_pkg::CFG_REG_PARAM, param_word(4, 0, 3));
        add_cfg(4, 1, snn_pkg::CFG_REG_PARAM, param_word(4, 0, 1));
        add_cfg(4, 2, snn_pkg::CFG_REG_PARAM, param_word(8, 0, 0));
        add_cfg(4, 3, snn_pkg::CFG_REG_PARAM, param_word(4, 0, 15));
        for (int k = 0; k < 20; k++) add_step(4, 32'h0000_000f, k % 2);
        // drive to the negative limit, recover, then clear with the lowest threshold
        for (int n = 0; n < N_NEURONS; n++) begin
            add_cfg(5, n, snn_pkg::CFG_REG_SIGN, '1);
            add_cfg(5, n, snn_pkg::CFG_REG_PARAM, param_word(100, (n == 3) ? 1 : 0, 0));
        end
        for (int k = 0; k < 1030; k++) add_step(5, 32'hffff_ffff, 0);
        // recovery threshold 168 above the negative limit
        for (int n = 0; n < N_NEURONS; n++) begin
            add_cfg(5, n, snn_pkg::CFG_REG_SIGN, 32'h0);
            add_cfg(5, n, snn_pkg::CFG_REG_PARAM, param_word(16'h80a8, (n == 3) ? 1 : 0, 0));
        end
        for (int k = 0; k < 6; k++) add_step(5, 32'hffff_ffff, 1);
        for (int n = 0; n < N_NEURONS; n++) begin
            add_cfg(5, n, snn_pkg::CFG_REG_PARAM, param_word(16'h8000, 0, 0));
        end
        add_step(5, 32'h0, 1);
        // back-to-back steps with writes squeezed between them
        for (int n = 0; n < N_NEURONS; n++) begin
            add_cfg(6, n, snn_pkg::CFG_REG_PARAM, param_word(2, 0, 0));
        end
        add_step(6, 32'h1, 0);
        add_step(6, 32'h1, 0);
        add_cfg(6, 0, snn_pkg::CFG_REG_CONN, 32'h0);
        add_step(6, 32'h3, 0);
        add_cfg(6, 1, snn_pkg::CFG_REG_PARAM, param_word(100, 0, 0));
        add_step(6, 32'h3, 0);
        add_cfg(6, 2, snn_pkg::CFG_REG_SIGN, '1);
        add_step(6, 32'hf, 0);
        add_step(6, 32'hf, 3);
        // random masks, parameters, spikes and gaps
        for (int n = 0; n < N_NEURONS; n++) begin
            r = lcg_next(r);
            add_cfg(7, n, snn_pkg::CFG_REG_CONN, r);
            r = lcg_next(r);
            add_cfg(7, n, snn_pkg::CFG_REG_SIGN, r);
            r = lcg_next(r);
            add_cfg(7, n, snn_pkg::CFG_REG_PARAM, param_word(16'(r[4:0]) + 1, r[9:8], r[13:12]));
        end
        for (int k = 0; k < 40; k++) begin
            r = lcg_next(r);
            add_step(7, r, int'(r[30:29]) % 3);
        end
    endfunction

    function automatic void predict_table();
        for (int n = 0; n < N_NEURONS; n++) begin
            m_conn[n] = '0;
            m_sign[n] = '0;
            m_thr[n] = 32767;
            m_leak[n] = 0;
            m_refr[n] = 0;
            m_mem[n] = 0;
            m_rcnt[n] = 0;
        end
        for (int i = 0; i < n_rows; i++) begin
            if (row_is_cfg[i]) begin
                model_write(row_addr[i], row_data[i]);
            end else begin
                row_exp[i] = model_step(row_data[i]);
            end
        end
    endfunction

    task automatic apply_row(input int i);
        @(posedge clk);
        if (row_is_cfg[i]) begin
            cfg_we <= 1'b1;
            cfg_addr <= row_addr[i];
            cfg_data <= row_data[i];
            step <= 1'b0;
        end else begin
            step <= 1'b1;
            spikes <= row_data[i];
            cfg_we <= 1'b0;
            due_q.push_back(cycle + VALID_DELAY);
            exp_q.push_back(row_exp[i]);
        end
        for (int g = 0; g < row_gap[i]; g++) begin
            @(posedge clk);
            step <= 1'b0;
            cfg_we <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        step <= 1'b0;
        cfg_we <= 1'b0;
        while (due_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (due_q.size() != 0) begin
            $display("timeout at %0t, %0d valid pulses never came", $time, due_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input int t, input int start_errors);
        if (errors == start_errors) begin
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("test %0d %s: %0d errors", t, test_name[t], errors - start_errors);
        end
    endtask

    // compare each valid pulse against the oldest queued step
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (due_q.size() == 0) begin
                $display("valid pulse at %0t with no step outstanding", $time);
                errors++;
            end else begin
                due_now = due_q.pop_front();
                exp_now = exp_q.pop_front();
                checks++;
                if (cycle != due_now) begin
                    $display("valid pulse at cycle %0d, step expected it at cycle %0d",
                             cycle, due_now);
                    errors++;
                end
                if (out_spikes !== exp_now) begin
                    $display("Fail at %0t: o_spikes expected %b got %b",
                             $time, exp_now, out_spikes);
                    errors++;
                end
            end
        end else if (!reset && due_q.size() != 0 && cycle >= due_q[0]) begin
            $display("valid pulse missing at cycle %0d", due_q[0]);
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            errors++;
        end
    end

    initial begin
        int cur_test;
        int start_errors;
        reset <= 1'b1;
        cfg_we <= 1'b0;
        cfg_addr <= '0;
        cfg_data <= '0;
        step <= 1'b0;
        spikes <= '0;
        test_name = '{"", "reset", "counting", "leak", "refractory",
                      "saturation", "pipeline", "random"};
        build_tables();
        predict_table();
        start_errors = 0;
        // outputs quiet through reset and a few idle cycles
        for (int c = 0; c < 7; c++) begin
            @(posedge clk);
            if (c == 2) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            checks++;
            if (out_valid !== 1'b0) begin
                $display("Fail at %0t: o_spikes_valid expected 0 got %b", $time, out_valid);
                errors++;
            end
            if (out_spikes !== '0) begin
                $display("Fail at %0t: o_spikes expected 0000 got %b", $time, out_spikes);
                errors++;
            end
        end
        cur_test = row_test[0];
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            if (row_test[i] != cur_test) begin
                wait_drain();
                report_test(cur_test, start_errors);
                cur_test = row_test[i];
                start_errors = errors;
            end
            apply_row(i);
        end
        wait_drain();
        report_test(cur_test, start_errors);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/snn_pkg.sv
hdl/spike_popcount8.sv
hdl/synapse_counter.sv
hdl/lif_neuron.sv
hdl/neuron_config.sv
hdl/snn_layer.sv
tests/snn_layer_tb.sv
